// File: Makefile
# Verilator simulation of the soc_bus interconnect

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_soc_bus -f soc_bus.f -o tb_soc_bus
	./obj_dir/tb_soc_bus > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  logic clk_i,
  input  logic arst_n,

  // initiator side
  input  logic [soc_bus_map_pkg::n_init-1:0]                             init_cyc,
  input  logic [soc_bus_map_pkg::n_init-1:0]                             init_stb,
  input  logic [soc_bus_map_pkg::n_init-1:0]                             init_we,
  input  logic [soc_bus_map_pkg::n_init-1:0][soc_bus_wb_pkg::adr_w-1:0] init_adr,
  input  logic [soc_bus_map_pkg::n_init-1:0][soc_bus_wb_pkg::dat_w-1:0] init_dat_w,
  input  logic [soc_bus_map_pkg::n_init-1:0][soc_bus_wb_pkg::sel_w-1:0] init_sel,
  output logic [soc_bus_map_pkg::n_init-1:0][soc_bus_wb_pkg::dat_w-1:0] init_dat_r,
  output logic [soc_bus_map_pkg::n_init-1:0]                             init_ack,
  output logic [soc_bus_map_pkg::n_init-1:0]                             init_err,

  // target side
  output logic [soc_bus_map_pkg::n_targ-1:0]                             targ_cyc,
  output logic [soc_bus_map_pkg::n_targ-1:0]                             targ_stb,
  output logic [soc_bus_map_pkg::n_targ-1:0]                             targ_we,
  output logic [soc_bus_map_pkg::n_targ-1:0][soc_bus_wb_pkg::adr_w-1:0] targ_adr,
  output logic [soc_bus_map_pkg::n_targ-1:0][soc_bus_wb_pkg::dat_w-1:0] targ_dat_w,
  output logic [soc_bus_map_pkg::n_targ-1:0][soc_bus_wb_pkg::sel_w-1:0] targ_sel,
  input  logic [soc_bus_map_pkg::n_targ-1:0][soc_bus_wb_pkg::dat_w-1:0] targ_dat_r,
  input  logic [soc_bus_map_pkg::n_targ-1:0]                             targ_ack
);

  logic [soc_bus_map_pkg::targ_idx_w-1:0] sel_idx     [soc_bus_map_pkg::n_init];
  logic                                   hit         [soc_bus_map_pkg::n_init];
  logic [soc_bus_map_pkg::n_init-1:0]     req         [soc_bus_map_pkg::n_targ];
  logic [soc_bus_map_pkg::n_init-1:0]     grant       [soc_bus_map_pkg::n_targ];
  logic                                   grant_valid [soc_bus_map_pkg::n_targ];
  logic [soc_bus_map_pkg::n_init-1:0]     err_q;

  for (genvar i = 0; i < soc_bus_map_pkg::n_init; i++) begin : gen_decode
    soc_bus_addr_decode u_decode (
      .adr          (init_adr[i]),
      .targ_sel_idx (sel_idx[i]),
      .hit          (hit[i])
    );
  end

  // live strobes sorted by the target they address
  always_comb begin
    for (int t = 0; t < soc_bus_map_pkg::n_targ; t++) begin
      for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
        req[t][i] = init_cyc[i] & init_stb[i] & hit[i] & (int'(sel_idx[i]) == t);
      end
    end
  end

  for (genvar t = 0; t < soc_bus_map_pkg::n_targ; t++) begin : gen_arb
    soc_bus_arbiter u_arb (
      .clk_i       (clk_i),
      .arst_n      (arst_n),
      .req         (req[t]),
      .cyc         (init_cyc),
      .grant       (grant[t]),
      .grant_valid (grant_valid[t])
    );
  end

  // request mux, owner of each target drives it
  always_comb begin
    targ_cyc   = '0;
    targ_stb   = '0;
    targ_we    = '0;
    targ_adr   = '0;
    targ_dat_w = '0;
    targ_sel   = '0;
    for (int t = 0; t < soc_bus_map_pkg::n_targ; t++) begin
      if (grant_valid[t]) begin
        for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
          if (grant[t][i]) begin
            targ_cyc[t]   = init_cyc[i];
            targ_stb[t]   = req[t][i];  // only while it still points here
            targ_we[t]    = init_we[i];
            targ_adr[t]   = init_adr[i];
            targ_dat_w[t] = init_dat_w[i];
            targ_sel[t]   = init_sel[i];
          end
        end
      end
    end
  end

  // response mux, same cycle as the target ack
  always_comb begin
    init_ack   = '0;
    init_dat_r = '0;
    for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
      for (int t = 0; t < soc_bus_map_pkg::n_targ; t++) begin
        if (grant[t][i] && req[t][i]) begin
          init_ack[i]   = targ_ack[t];
          init_dat_r[i] = targ_dat_r[t];
        end
      end
    end
  end

  // decode error, one pulse per strobe into the hole
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= '0;
    end else begin
      for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
        err_q[i] <= init_cyc[i] & init_stb[i] & ~hit[i] & ~err_q[i];
      end
    end
  end

  assign init_err = err_q;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n)
    (init_ack & init_err) == '0)
    else $error("ack and err together on initiators %b", init_ack & init_err);

endmodule

`default_nettype wire

// File: hdl/soc_bus_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_addr_decode (
  input  logic [soc_bus_wb_pkg::adr_w-1:0]       adr,
  output logic [soc_bus_map_pkg::targ_idx_w-1:0] targ_sel_idx,
  output logic                                   hit
);

  soc_bus_wb_pkg::soc_adr_u adr_u;

  assign adr_u.raw = adr;

  // first matching rule wins
  always_comb begin
    targ_sel_idx = soc_bus_map_pkg::targ_ext;
    hit          = 1'b1;
    if (adr_u.raw >= soc_bus_map_pkg::l2_base &&
        adr_u.raw <  soc_bus_map_pkg::l2_base + soc_bus_map_pkg::l2_size) begin
      targ_sel_idx = soc_bus_map_pkg::targ_l2;  // shadows the upper ext window
    end else if (adr_u.raw >= soc_bus_map_pkg::dbg_base &&
                 adr_u.raw <  soc_bus_map_pkg::dbg_base + soc_bus_map_pkg::dbg_size) begin
      targ_sel_idx = soc_bus_map_pkg::targ_dbg;
    end else if (adr_u.cl.region == soc_bus_map_pkg::cl_base[31:23] &&
                 adr_u.cl.cl_idx == 1'b0) begin
      targ_sel_idx = soc_bus_map_pkg::targ_cl0;
    end else if (adr_u.cl.region == soc_bus_map_pkg::cl_base[31:23] &&
                 adr_u.cl.cl_idx == 1'b1) begin
      targ_sel_idx = soc_bus_map_pkg::targ_cl1;
    end else if (adr_u.raw < soc_bus_map_pkg::ext_low_end) begin
      targ_sel_idx = soc_bus_map_pkg::targ_ext;
    end else if (adr_u.raw >= soc_bus_map_pkg::dbg_base + soc_bus_map_pkg::dbg_size) begin
      targ_sel_idx = soc_bus_map_pkg::targ_ext;  // rest of the space above debug
    end else begin
      // hole between the clusters and debug
      targ_sel_idx = soc_bus_map_pkg::targ_ext;
      hit          = 1'b0;
    end
  end

  // sampled whenever the address moves, so each settled result is checked
  a_idx_in_range: assert property (@(adr)
    hit |-> int'(targ_sel_idx) < soc_bus_map_pkg::n_targ)
    else $error("decoder selected target %0d, beyond the target count", targ_sel_idx);

endmodule

`default_nettype wire

// File: hdl/soc_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_arbiter (
  input  logic                                clk_i,
  input  logic                                arst_n,
  input  logic [soc_bus_map_pkg::n_init-1:0] req,
  input  logic [soc_bus_map_pkg::n_init-1:0] cyc,
  output logic [soc_bus_map_pkg::n_init-1:0] grant,
  output logic                                grant_valid
);

  logic [soc_bus_map_pkg::n_init-1:0]         grant_q;
  logic [soc_bus_map_pkg::n_init-1:0]         grant_d;
  logic [$clog2(soc_bus_map_pkg::n_init)-1:0] last_q;   // last winner
  logic [$clog2(soc_bus_map_pkg::n_init)-1:0] win_idx;
  logic                                       hold;

  // winner keeps the target while its cycle runs
  assign hold = |(grant_q & cyc);

  always_comb begin
    int unsigned idx;
    idx     = 0;
    grant_d = grant_q;
    win_idx = last_q;
    if (!hold) begin
      grant_d = '0;
      // walk from the far end so the nearest requester after last_q wins
      for (int unsigned k = soc_bus_map_pkg::n_init; k > 0; k--) begin
        idx = (last_q + k) % soc_bus_map_pkg::n_init;
        if (req[idx]) begin
          grant_d      = '0;
          grant_d[idx] = 1'b1;
          win_idx      = idx[$clog2(soc_bus_map_pkg::n_init)-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      grant_q <= '0;
      last_q  <= '1;  // initiator 0 goes first
    end else begin
      grant_q <= grant_d;
      last_q  <= win_idx;
    end
  end

  assign grant       = grant_q;
  assign grant_valid = |grant_q;

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n)
    $onehot0(grant))
    else $error("arbiter grant %b is not one-hot", grant);

  // no switch while the owner still has cyc up
  a_grant_locked: assert property (@(posedge clk_i) disable iff (!arst_n)
    |(grant & cyc) |=> grant == $past(grant))
    else $error("arbiter grant moved during an open cycle");

endmodule

`default_nettype wire

// File: hdl/soc_bus_map_pkg.sv
`default_nettype none

package soc_bus_map_pkg;

  // bus size
  localparam int unsigned n_init = 4;
  localparam int unsigned n_targ = 5;

  // initiator slots
  localparam int unsigned init_cl0 = 0;
  localparam int unsigned init_cl1 = 1;
  localparam int unsigned init_ext = 2;  // external host
  localparam int unsigned init_dbg = 3;

  // target slots, as seen by the decoder
  localparam int unsigned targ_idx_w = 3;

  localparam logic [targ_idx_w-1:0] targ_cl0 = 3'd0;
  localparam logic [targ_idx_w-1:0] targ_cl1 = 3'd1;
  localparam logic [targ_idx_w-1:0] targ_l2  = 3'd2;
  localparam logic [targ_idx_w-1:0] targ_ext = 3'd3;
  localparam logic [targ_idx_w-1:0] targ_dbg = 3'd4;

  // address map, 32 bit
  localparam logic [31:0] cl_base = 32'h1000_0000;  // cluster 0, cluster 1 follows
  localparam logic [31:0] cl_size = 32'h0040_0000;  // 4 MiB each

  localparam logic [31:0] l2_base = 32'h1C00_0000;
  localparam logic [31:0] l2_size = 32'h0010_0000;  // 1 MiB

  localparam logic [31:0] dbg_base = 32'h1A11_0000;
  localparam logic [31:0] dbg_size = 32'h0000_1000;  // 4 KiB

  // lower external window is 0 up to here
  // upper external window starts right after debug
  localparam logic [31:0] ext_low_end = 32'h1000_0000;

endpackage

`default_nettype wire

// File: hdl/soc_bus_wb_pkg.sv
`default_nettype none

package soc_bus_wb_pkg;

  // wishbone classic port widths
  localparam int unsigned adr_w = 32;
  localparam int unsigned dat_w = 32;
  localparam int unsigned sel_w = dat_w / 8;  // one select per byte

  // address word, flat or split for the cluster windows
  typedef union packed {
    logic [adr_w-1:0] raw;
    struct packed {
      logic [8:0]  region;  // 8 MiB block holding both clusters
      logic        cl_idx;  // which cluster
      logic [21:0] cl_off;  // offset inside the 4 MiB window
    } cl;
  } soc_adr_u;

endpackage

`default_nettype wire

// File: soc_bus.f
hdl/soc_bus_map_pkg.sv
hdl/soc_bus_wb_pkg.sv
hdl/soc_bus_addr_decode.sv
hdl/soc_bus_arbiter.sv
hdl/soc_bus.sv
testbench/tb_soc_bus_checker.sv
testbench/tb_soc_bus.sv

// File: testbench/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

  localparam int n_rows = 23;

  typedef struct {
    int          ia;       // first initiator
    int          ib;       // second initiator, -1 for none
    bit          we;
    logic [31:0] adr_a;
    logic [31:0] adr_b;
    logic [31:0] dat;      // second initiator writes the inverse
    logic [3:0]  sel;
    bit          exp_err;
    bit          par;      // targets differ, no waiting on each other
  } row_t;

  logic clk_i = 1'b0;
  logic arst_n;
  logic [3:0]       init_cyc, init_stb, init_we, init_ack, init_err;
  logic [3:0][31:0] init_adr, init_dat_w, init_dat_r;
  logic [3:0][3:0]  init_sel;
  logic [4:0]       targ_cyc, targ_stb, targ_we, targ_ack;
  logic [4:0][31:0] targ_adr, targ_dat_w, targ_dat_r;
  logic [4:0][3:0]  targ_sel;

  logic [31:0] mem [5][16];
  int          wait_cnt [5];
  bit          active [5];
  row_t        rows [n_rows];
  bit          res_err [4];
  int          res_cyc [4];
  int          row_fail;
  int          fail_cnt;
  int          cycle_cnt;
  logic        done;
  int          first_i;    // initiator served first in a contention round
  int          pair_m;
  int          prev_pair;
  int          prev_last;

  soc_bus u_dut (.*);

  tb_soc_bus_checker u_chk (
    .clk_i, .init_cyc, .init_stb, .init_we, .init_adr, .init_dat_w, .init_sel,
    .init_dat_r, .init_ack, .init_err, .targ_cyc, .targ_stb, .targ_adr, .done, .row_fail,
    .fail_cnt
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > n_rows * 40) begin
      $display("timeout after %0d cycles, a transfer never finished", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // target memories, decide on the falling edge, drive after the rising one
  always @(negedge clk_i) begin
    logic [4:0]       ack_n;
    logic [4:0][31:0] dat_n;
    int               w;
    ack_n = '0;
    dat_n = targ_dat_r;
    for (int t = 0; t < 5; t++) begin
      if (targ_ack[t]) begin
        active[t] = 0;
      end else if (targ_cyc[t] && targ_stb[t]) begin
        if (!active[t]) begin
          active[t]   = 1;
          wait_cnt[t] = $urandom % 4;
        end
        if (wait_cnt[t] == 0) begin
          w = int'(targ_adr[t][5:2]);
          if (targ_we[t]) begin
            for (int b = 0; b < 4; b++)
              if (targ_sel[t][b]) mem[t][w][8*b +: 8] = targ_dat_w[t][8*b +: 8];
          end else dat_n[t] = mem[t][w];
          ack_n[t] = 1'b1;
        end else wait_cnt[t]--;
      end
    end
    @(posedge clk_i);
    #1;
    targ_ack   = ack_n;
    targ_dat_r = dat_n;
  end

  task automatic do_xfer(input int i, input bit we, input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel, output bit err, output int cyc_n);
    cyc_n         = 0;
    init_we[i]    = we;
    init_adr[i]   = adr;
    init_dat_w[i] = dat;
    init_sel[i]   = sel;
    init_cyc[i]   = 1'b1;
    init_stb[i]   = 1'b1;
    do begin
      @(negedge clk_i);
      cyc_n++;
    end while (!init_ack[i] && !init_err[i]);
    err = init_err[i];
    @(posedge clk_i);
    #1;
    init_cyc[i] = 1'b0;
    init_stb[i] = 1'b0;
  endtask

  task automatic check_outcome(input int r, input int i);
    if (res_err[i] != rows[r].exp_err) begin
      $display("row %0d: initiator %0d ended with %s, expected %s", r, i,
               res_err[i] ? "err" : "ack", rows[r].exp_err ? "err" : "ack");
      row_fail++;
    end
    // grant cycle, target response cycle and up to 3 wait states
    if (rows[r].par && res_cyc[i] > 6) begin
      $display("row %0d: initiator %0d waited %0d cycles on another target", r, i, res_cyc[i]);
      row_fail++;
    end
  endtask

  initial begin
    rows = '{
      '{0, -1, 1, 32'h1000_0010, 32'h0, 32'h1111_1111, 4'hf, 0, 0},
      '{0, -1, 0, 32'h1000_0010, 32'h0, 32'h0,         4'hf, 0, 0},
      '{1, -1, 1, 32'h1040_0020, 32'h0, 32'h2222_2222, 4'hf, 0, 0},
      '{1, -1, 0, 32'h1040_0020, 32'h0, 32'h0,         4'hf, 0, 0},
      '{2, -1, 1, 32'h1C00_0000, 32'h0, 32'h3333_3333, 4'hf, 0, 0},  // l2, not ext
      '{3, -1, 0, 32'h1C00_0000, 32'h0, 32'h0,         4'hf, 0, 0},
      '{3, -1, 1, 32'h1A11_0004, 32'h0, 32'h4444_4444, 4'hf, 0, 0},
      '{0, -1, 0, 32'h1A11_0004, 32'h0, 32'h0,         4'hf, 0, 0},
      '{2, -1, 1, 32'h0000_0100, 32'h0, 32'h5555_5555, 4'hf, 0, 0},
      '{1, -1, 0, 32'h0000_0100, 32'h0, 32'h0,         4'hf, 0, 0},
      '{0, -1, 1, 32'h2000_0008, 32'h0, 32'h6666_6666, 4'hf, 0, 0},
      '{0, -1, 0, 32'h2000_0008, 32'h0, 32'h0,         4'hf, 0, 0},
      '{1, -1, 1, 32'h1C00_0000, 32'h0, 32'haabb_ccdd, 4'h5, 0, 0},  // partial sel
      '{2, -1, 0, 32'h1C00_0000, 32'h0, 32'h0,         4'hf, 0, 0},
      '{2, -1, 0, 32'h1080_0000, 32'h0, 32'h0,         4'hf, 1, 0},  // hole
      '{2, -1, 1, 32'h1A10_FFFC, 32'h0, 32'hdead_beef, 4'hf, 1, 0},
      '{2, -1, 0, 32'h0000_0100, 32'h0, 32'h0,         4'hf, 0, 0},
      '{0,  1, 1, 32'h1C00_0008, 32'h1C00_000C, 32'h7777_7777, 4'hf, 0, 0},
      '{0,  1, 0, 32'h1C00_0008, 32'h1C00_000C, 32'h0,         4'hf, 0, 0},
      '{2,  3, 1, 32'h1C00_0008, 32'h1C00_000C, 32'h8888_8888, 4'hf, 0, 0},
      '{3,  2, 0, 32'h1C00_0008, 32'h1C00_000C, 32'h0,         4'hf, 0, 0},
      '{0,  3, 1, 32'h1000_0030, 32'h1A11_0008, 32'h9999_9999, 4'hf, 0, 1},
      '{0,  3, 0, 32'h1000_0030, 32'h1A11_0008, 32'h0,         4'hf, 0, 1}
    };
    void'($urandom(32'hb793e474));
    for (int t = 0; t < 5; t++) begin
      active[t]   = 0;
      wait_cnt[t] = 0;
      for (int w = 0; w < 16; w++) mem[t][w] = 32'h5a5a_0000 | 32'(t << 8) | 32'(w);
    end
    init_cyc   = '0;
    init_stb   = '0;
    init_we    = '0;
    init_adr   = '0;
    init_dat_w = '0;
    init_sel   = '0;
    targ_ack   = '0;
    targ_dat_r = '0;
    row_fail   = 0;
    cycle_cnt  = 0;
    prev_pair  = 0;
    prev_last  = -1;
    done       = 1'b0;
    arst_n     = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 arst_n = 1'b1;
    repeat (2) @(posedge clk_i);  // idle bus after reset
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk_i);
      #1;
      fork
        do_xfer(rows[r].ia, rows[r].we, rows[r].adr_a, rows[r].dat, rows[r].sel,
                res_err[rows[r].ia], res_cyc[rows[r].ia]);
        begin
          if (rows[r].ib >= 0)
            do_xfer(rows[r].ib, rows[r].we, rows[r].adr_b, ~rows[r].dat, rows[r].sel,
                    res_err[rows[r].ib], res_cyc[rows[r].ib]);
        end
      join
      check_outcome(r, rows[r].ia);
      if (rows[r].ib >= 0) check_outcome(r, rows[r].ib);
      // round robin, the one served last must not go first next round
      if (rows[r].ib >= 0 && !rows[r].par) begin
        first_i = res_cyc[rows[r].ia] < res_cyc[rows[r].ib] ? rows[r].ia : rows[r].ib;
        pair_m  = (1 << rows[r].ia) | (1 << rows[r].ib);
        if (pair_m == prev_pair && first_i == prev_last) begin
          $display("row %0d: initiator %0d served twice in a row, grant did not alternate",
                   r, first_i);
          row_fail++;
        end
        prev_pair = pair_m;
        prev_last = first_i == rows[r].ia ? rows[r].ib : rows[r].ia;
      end
      $display("row %0d finished, initiator %0d took %0d cycles", r, rows[r].ia,
               res_cyc[rows[r].ia]);
    end
    repeat (2) @(posedge clk_i);
    done = 1'b1;
    #1;
    if (fail_cnt == 0 && row_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_soc_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus_checker (
  input  logic                                    clk_i,
  input  logic [soc_bus_map_pkg::n_init-1:0]       init_cyc,
  input  logic [soc_bus_map_pkg::n_init-1:0]       init_stb,
  input  logic [soc_bus_map_pkg::n_init-1:0]       init_we,
  input  logic [soc_bus_map_pkg::n_init-1:0][31:0] init_adr,
  input  logic [soc_bus_map_pkg::n_init-1:0][31:0] init_dat_w,
  input  logic [soc_bus_map_pkg::n_init-1:0][3:0]  init_sel,
  input  logic [soc_bus_map_pkg::n_init-1:0][31:0] init_dat_r,
  input  logic [soc_bus_map_pkg::n_init-1:0]       init_ack,
  input  logic [soc_bus_map_pkg::n_init-1:0]       init_err,
  input  logic [soc_bus_map_pkg::n_targ-1:0]       targ_cyc,
  input  logic [soc_bus_map_pkg::n_targ-1:0]       targ_stb,
  input  logic [soc_bus_map_pkg::n_targ-1:0][31:0] targ_adr,
  input  logic                                    done,
  input  int                                      row_fail,
  output int                                      fail_cnt
);

  logic [31:0] shadow [soc_bus_map_pkg::n_targ][16];
  int          start [soc_bus_map_pkg::n_init];
  bit          pending [soc_bus_map_pkg::n_init];
  bit          seen_req;
  int          pos_cnt;
  int          pass_cnt;

  // expected target from the map rules, -1 for the hole
  function automatic int expect_target(input logic [31:0] a);
    soc_bus_wb_pkg::soc_adr_u u;
    u.raw = a;
    if (a >= soc_bus_map_pkg::l2_base && a < soc_bus_map_pkg::l2_base + soc_bus_map_pkg::l2_size)
      return int'(soc_bus_map_pkg::targ_l2);
    if (a >= soc_bus_map_pkg::dbg_base &&
        a < soc_bus_map_pkg::dbg_base + soc_bus_map_pkg::dbg_size)
      return int'(soc_bus_map_pkg::targ_dbg);
    if (u.cl.region == soc_bus_map_pkg::cl_base[31:23])
      return u.cl.cl_idx ? int'(soc_bus_map_pkg::targ_cl1) : int'(soc_bus_map_pkg::targ_cl0);
    if (a < soc_bus_map_pkg::ext_low_end)
      return int'(soc_bus_map_pkg::targ_ext);
    if (a >= soc_bus_map_pkg::dbg_base + soc_bus_map_pkg::dbg_size)
      return int'(soc_bus_map_pkg::targ_ext);
    return -1;
  endfunction

  initial begin
    fail_cnt = 0;
    pass_cnt = 0;
    pos_cnt  = 0;
    seen_req = 0;
    for (int t = 0; t < soc_bus_map_pkg::n_targ; t++)
      for (int w = 0; w < 16; w++)
        shadow[t][w] = 32'h5a5a_0000 | 32'(t << 8) | 32'(w);  // same fill as the models
    for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
      pending[i] = 0;
      start[i]   = 0;
    end
  end

  always @(posedge clk_i) pos_cnt++;

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    int t;
    int w;
    if (init_cyc != '0) seen_req = 1;
    if (!seen_req && (targ_cyc != '0 || targ_stb != '0 || init_ack != '0 || init_err != '0)) begin
      $display("bus activity at %0t before any request was made", $time);
      fail_cnt++;
    end
    for (int i = 0; i < soc_bus_map_pkg::n_init; i++) begin
      if (init_cyc[i] && init_stb[i] && !pending[i]) begin
        pending[i] = 1;
        start[i]   = pos_cnt;
      end
      t = expect_target(init_adr[i]);
      w = int'(init_adr[i][5:2]);
      if (pending[i] && init_err[i]) begin
        pending[i] = 0;
        if (t >= 0) begin
          $display("initiator %0d got err at %0t on mapped address %h", i, $time, init_adr[i]);
          fail_cnt++;
        end else if (pos_cnt - start[i] != 1) begin
          $display("FAILED %0t init_err[%0d] delay expected 1 got %0d",
                   $time, i, pos_cnt - start[i]);
          fail_cnt++;
        end else pass_cnt++;
      end else if (pending[i] && init_ack[i]) begin
        pending[i] = 0;
        if (t < 0) begin
          $display("initiator %0d got ack at %0t on unmapped address %h", i, $time, init_adr[i]);
          fail_cnt++;
        end else if (init_we[i]) begin
          for (int b = 0; b < 4; b++)
            if (init_sel[i][b]) shadow[t][w][8*b +: 8] = init_dat_w[i][8*b +: 8];
          pass_cnt++;
        end else if (init_dat_r[i] !== shadow[t][w]) begin
          $display("FAILED %0t init_dat_r[%0d] expected %h got %h",
                   $time, i, shadow[t][w], init_dat_r[i]);
          fail_cnt++;
        end else pass_cnt++;
      end
    end
    for (int k = 0; k < soc_bus_map_pkg::n_targ; k++) begin
      if (targ_stb[k] && expect_target(targ_adr[k]) != k) begin
        $display("FAILED %0t targ_stb[%0d] for address %h expected target %0d got %0d",
                 $time, k, targ_adr[k], expect_target(targ_adr[k]), k);
        fail_cnt++;
      end
    end
  end

  always @(posedge done)
    $display("transfers passed %0d failed %0d, rows failed %0d", pass_cnt, fail_cnt, row_fail);

endmodule

`default_nettype wire
